// File: bru.f
+incdir+hdl
hdl/bru_pkg.sv
hdl/branch_compare.sv
hdl/branch_unit.sv
hdl/bru_ctrl.sv
hdl/bru_top.sv
tb/tb_clk_gen.sv
tb/tb_bru.sv

// File: hdl/branch_compare.sv
`timescale 1ns/10ps
`include "bru_config.svh"

module branch_compare (
  input  bru_pkg::bru_issue_t issue_i,
  output logic                comp_res_o
);

  // signed views of both operands for BLT and BGE
  logic signed [`BRU_XLEN-1:0] op_a_s;
  logic signed [`BRU_XLEN-1:0] op_b_s;

  assign op_a_s = $signed(issue_i.operand_a);
  assign op_b_s = $signed(issue_i.operand_b);

  // evaluate the branch condition selected by the operation
  always_comb begin : compare
    comp_res_o = 1'b0;
    case (issue_i.op)
      bru_pkg::BEQ: begin
        comp_res_o = (issue_i.operand_a == issue_i.operand_b);
      end
      bru_pkg::BNE: begin
        comp_res_o = (issue_i.operand_a != issue_i.operand_b);
      end
      // two's complement ordering
      bru_pkg::BLT: begin
        comp_res_o = (op_a_s < op_b_s);
      end
      bru_pkg::BGE: begin
        comp_res_o = (op_a_s >= op_b_s);
      end
      // plain magnitude ordering
      bru_pkg::BLTU: begin
        comp_res_o = (issue_i.operand_a < issue_i.operand_b);
      end
      bru_pkg::BGEU: begin
        comp_res_o = (issue_i.operand_a >= issue_i.operand_b);
      end
      // jumps are unconditional, so they always count as taken
      bru_pkg::JAL,
      bru_pkg::JALR: begin
        comp_res_o = 1'b1;
      end
      default: begin
        comp_res_o = 1'b0;
      end
    endcase
  end

endmodule

// File: hdl/branch_unit.sv
`timescale 1ns/10ps
`include "bru_config.svh"

module branch_unit (
  input  logic                     valid_i,
  input  bru_pkg::bru_issue_t      issue_i,
  input  bru_pkg::branch_predict_t predict_i,
  input  logic                     comp_res_i,
  output bru_pkg::xlen_t           branch_result_o,
  output bru_pkg::bp_resolve_t     resolved_branch_o,
  output logic                     resolve_branch_o,
  output bru_pkg::exception_t      branch_exception_o
);

  // base of the target sum, the register for JALR and the PC for the rest
  bru_pkg::vaddr_t jump_base;
  // computed destination if the control transfer is taken
  bru_pkg::vaddr_t target_address;
  // address of the following instruction, also the link value
  bru_pkg::vaddr_t next_pc;
  // set for the six conditional branches
  logic            is_branch;
  // set when control actually leaves the sequential path
  logic            jump_taken;
  // set when the target breaks the alignment rule
  logic            misaligned;

  assign is_branch = bru_pkg::op_is_branch(issue_i.op);

  assign jump_base = (issue_i.op == bru_pkg::JALR) ?
                     issue_i.operand_a[`BRU_VLEN-1:0] : issue_i.pc;

  // the instruction length decides how far the link address moves on
  assign next_pc = issue_i.pc + (issue_i.is_compressed ? bru_pkg::vaddr_t'(2) :
                                                         bru_pkg::vaddr_t'(4));

  // the immediate is sign extended, so plain wrap-around addition is enough
  always_comb begin : target_calc
    target_address = jump_base + issue_i.imm[`BRU_VLEN-1:0];
    // JALR drops the lowest bit of the sum
    if (issue_i.op == bru_pkg::JALR) begin
      target_address[0] = 1'b0;
    end
  end

  // the link address is what the unit writes back to rd
  assign branch_result_o = bru_pkg::xlen_t'(next_pc);

  // resolution and mispredict detection
  always_comb begin : mispredict_check
    resolve_branch_o                 = valid_i;
    resolved_branch_o.valid          = valid_i;
    resolved_branch_o.pc             = issue_i.pc;
    resolved_branch_o.target_address = '0;
    resolved_branch_o.is_taken       = 1'b0;
    resolved_branch_o.is_mispredict  = 1'b0;
    // by default the predicted kind is handed back unchanged
    resolved_branch_o.cf_type        = predict_i.cf;
    if (valid_i) begin
      // a not-taken branch falls through to the next instruction
      resolved_branch_o.target_address = comp_res_i ? target_address : next_pc;
      resolved_branch_o.is_taken       = comp_res_i;
      if (is_branch) begin
        // the direction predictor is right only if taken matches a Branch guess
        resolved_branch_o.cf_type       = bru_pkg::Branch;
        resolved_branch_o.is_mispredict = comp_res_i != (predict_i.cf == bru_pkg::Branch);
      end
      // a register jump needs both a prediction and the right address
      if (issue_i.op == bru_pkg::JALR &&
          (predict_i.cf == bru_pkg::NoCF ||
           target_address != predict_i.predict_address)) begin
        resolved_branch_o.is_mispredict = 1'b1;
        // returns live in the return stack, so the BTB is left alone for them
        if (predict_i.cf != bru_pkg::Return) begin
          resolved_branch_o.cf_type = bru_pkg::JumpR;
        end
      end
    end
  end

  // JAL and JALR always transfer control, a branch only when its condition holds
  assign jump_taken = !is_branch || comp_res_i;

  // bit 0 must be clear in any case, bit 1 as well when there are no 16-bit instructions
  assign misaligned = target_address[0] || ((`BRU_RVC == 0) && target_address[1]);

  always_comb begin : exception_check
    branch_exception_o.valid = valid_i && jump_taken && misaligned;
    branch_exception_o.cause = bru_pkg::INSTR_ADDR_MISALIGNED;
    // the faulting PC goes into tval only if trap values are enabled
    branch_exception_o.tval  = (`BRU_TVAL_EN != 0) ? bru_pkg::xlen_t'(issue_i.pc) : '0;
  end

endmodule

// File: hdl/bru_config.svh
`ifndef BRU_CONFIG_SVH
`define BRU_CONFIG_SVH

// width of an instruction address in bits
`define BRU_VLEN 32

// width of a register operand and of a result in bits
`define BRU_XLEN 32

// set to 1 when the compressed extension is present
// with it, a target only has to be aligned to 2 bytes
// without it, 4 bytes are required
`define BRU_RVC 1

// set to 1 when a misaligned-target trap reports the faulting PC in tval
// with 0, tval stays zero
`define BRU_TVAL_EN 1

`endif

// File: hdl/bru_ctrl.sv
`timescale 1ns/10ps
`include "bru_config.svh"

module bru_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     issue_valid_i,
  input  bru_pkg::bru_issue_t      issue_i,
  input  bru_pkg::branch_predict_t predict_i,
  input  bru_pkg::bp_resolve_t     resolved_branch_i,
  input  logic                     resolve_branch_i,
  input  bru_pkg::xlen_t           branch_result_i,
  input  bru_pkg::exception_t      branch_exception_i,
  output logic                     s2_valid_o,
  output bru_pkg::bru_issue_t      s2_issue_o,
  output bru_pkg::branch_predict_t s2_predict_o,
  output logic                     resolve_o,
  output bru_pkg::bp_resolve_t     resolved_branch_o,
  output bru_pkg::xlen_t           branch_result_o,
  output bru_pkg::exception_t      branch_exception_o
);

  bru_pkg::bru_state_e state_q;
  bru_pkg::bru_state_e state_d;

  // stage 2 holds a mispredicted instruction in this cycle
  logic mispredict;
  // the current issue strobe is on the correct path and is taken in
  logic accept;

  assign mispredict = resolved_branch_i.valid && resolved_branch_i.is_mispredict;

  // the first wrong-path issue arrives together with the mispredict,
  // the second one during the single FLUSH cycle that follows
  assign accept = issue_valid_i && !mispredict && (state_q == bru_pkg::RUN);

  // flush state machine
  always_comb begin : flush_fsm
    state_d = state_q;
    case (state_q)
      bru_pkg::RUN: begin
        if (mispredict) begin
          state_d = bru_pkg::FLUSH;
        end
      end
      // one cycle is enough to cover the redirect latency of the front end
      bru_pkg::FLUSH: begin
        state_d = bru_pkg::RUN;
      end
      default: begin
        state_d = bru_pkg::RUN;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin : state_reg
    if (rst_i) begin
      state_q <= bru_pkg::RUN;
    end else begin
      state_q <= state_d;
    end
  end

  // stage 2 is empty after reset and then holds each accepted issue for one cycle
  always_ff @(posedge clk_i) begin : s2_valid_reg
    if (rst_i) begin
      s2_valid_o <= 1'b0;
    end else begin
      s2_valid_o <= accept;
    end
  end

  // the stage 2 payload follows every accepted issue and keeps its value otherwise
  always_ff @(posedge clk_i) begin : s2_payload_reg
    if (accept) begin
      s2_issue_o   <= issue_i;
      s2_predict_o <= predict_i;
    end
  end

  // the output register reloads on every edge so that a resolution shows for one cycle
  always_ff @(posedge clk_i) begin : out_reg
    if (rst_i) begin
      resolve_o          <= 1'b0;
      resolved_branch_o  <= '0;
      branch_result_o    <= '0;
      branch_exception_o <= '0;
    end else begin
      resolve_o          <= resolve_branch_i;
      resolved_branch_o  <= resolved_branch_i;
      branch_result_o    <= branch_result_i;
      branch_exception_o <= branch_exception_i;
    end
  end

endmodule

// File: hdl/bru_pkg.sv
`include "bru_config.svh"

package bru_pkg;

  // an instruction address as seen by the front end
  typedef logic [`BRU_VLEN-1:0] vaddr_t;

  // a register operand, an immediate or a written-back result
  typedef logic [`BRU_XLEN-1:0] xlen_t;

  // control-flow operations handled by the branch stage
  typedef enum logic [2:0] {
    BEQ,
    BNE,
    BLT,
    BGE,
    BLTU,
    BGEU,
    JAL,
    JALR
  } bru_op_e;

  // kind of control flow, both as predicted and as resolved
  // the predictor tables are updated according to this field
  typedef enum logic [2:0] {
    NoCF,
    Branch,
    Jump,
    JumpR,
    Return
  } cf_e;

  // one issued control-flow instruction
  typedef struct packed {
    bru_op_e op;
    xlen_t   operand_a;
    xlen_t   operand_b;
    xlen_t   imm;
    vaddr_t  pc;
    logic    is_compressed;
  } bru_issue_t;

  // what the front end guessed for this instruction
  typedef struct packed {
    cf_e    cf;
    vaddr_t predict_address;
  } branch_predict_t;

  // resolution sent back to the front end and the predictor
  typedef struct packed {
    logic   valid;
    vaddr_t pc;
    vaddr_t target_address;
    logic   is_taken;
    logic   is_mispredict;
    cf_e    cf_type;
  } bp_resolve_t;

  // synchronous exception raised by the stage
  typedef struct packed {
    logic  valid;
    xlen_t cause;
    xlen_t tval;
  } exception_t;

  // the stage runs normally or squashes wrong-path issues
  typedef enum logic {
    RUN,
    FLUSH
  } bru_state_e;

  // privileged spec cause code for a misaligned instruction address
  localparam xlen_t INSTR_ADDR_MISALIGNED = '0;

  // true for the six conditional branches, false for JAL and JALR
  function automatic logic op_is_branch(bru_op_e op);
    return op inside {BEQ, BNE, BLT, BGE, BLTU, BGEU};
  endfunction

endpackage

// File: hdl/bru_top.sv
`timescale 1ns/10ps
`include "bru_config.svh"

module bru_top (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     issue_valid_i,
  input  bru_pkg::bru_issue_t      issue_i,
  input  bru_pkg::branch_predict_t predict_i,
  output logic                     resolve_o,
  output bru_pkg::bp_resolve_t     resolved_branch_o,
  output bru_pkg::xlen_t           branch_result_o,
  output bru_pkg::exception_t      branch_exception_o
);

  // registered instruction that is being resolved in stage 2
  logic                     s2_valid;
  bru_pkg::bru_issue_t      s2_issue;
  bru_pkg::branch_predict_t s2_predict;

  // condition outcome of the instruction in stage 2
  logic                     comp_res;

  // unregistered results heading back into the control block
  bru_pkg::bp_resolve_t     unit_resolved;
  logic                     unit_resolve;
  bru_pkg::xlen_t           unit_result;
  bru_pkg::exception_t      unit_exception;

  // issue register, flush handling and output register
  bru_ctrl i_bru_ctrl (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .issue_valid_i      (issue_valid_i),
    .issue_i            (issue_i),
    .predict_i          (predict_i),
    .resolved_branch_i  (unit_resolved),
    .resolve_branch_i   (unit_resolve),
    .branch_result_i    (unit_result),
    .branch_exception_i (unit_exception),
    .s2_valid_o         (s2_valid),
    .s2_issue_o         (s2_issue),
    .s2_predict_o       (s2_predict),
    .resolve_o          (resolve_o),
    .resolved_branch_o  (resolved_branch_o),
    .branch_result_o    (branch_result_o),
    .branch_exception_o (branch_exception_o)
  );

  // operand comparison
  branch_compare i_branch_compare (
    .issue_i    (s2_issue),
    .comp_res_o (comp_res)
  );

  // target, link, mispredict and alignment check
  branch_unit i_branch_unit (
    .valid_i            (s2_valid),
    .issue_i            (s2_issue),
    .predict_i          (s2_predict),
    .comp_res_i         (comp_res),
    .branch_result_o    (unit_result),
    .resolved_branch_o  (unit_resolved),
    .resolve_branch_o   (unit_resolve),
    .branch_exception_o (unit_exception)
  );

endmodule

// File: tb/tb_bru.sv
`timescale 1ns/10ps
`include "bru_config.svh"

module tb_bru;

  localparam int CLK_PERIOD   = 100;
  localparam int RST_CYCLES   = 4;
  localparam int NUM_CYCLES   = 2000;
  localparam int DRAIN_CYCLES = 8;
  localparam int RUN_CYCLES   = RST_CYCLES + NUM_CYCLES + DRAIN_CYCLES;
  localparam int TIMEOUT_CYCLES = RUN_CYCLES + 20;
  localparam bru_pkg::xlen_t SIGN_BIT = bru_pkg::xlen_t'(1) << (`BRU_XLEN - 1);

  // one expected output word and the edge after which it must show up
  typedef struct packed {
    bru_pkg::bp_resolve_t res;
    bru_pkg::xlen_t       result;
    bru_pkg::exception_t  exc;
    logic [31:0]          due;
  } expect_t;

  logic                     clk;
  logic                     rst_i;
  logic                     issue_valid_i;
  bru_pkg::bru_issue_t      issue_i;
  bru_pkg::branch_predict_t predict_i;
  logic                     resolve_o;
  bru_pkg::bp_resolve_t     resolved_branch_o;
  bru_pkg::xlen_t           branch_result_o;
  bru_pkg::exception_t      branch_exception_o;

  logic [31:0] rng_state = 32'h7609;
  logic [31:0] edge_cnt  = '0;
  logic        last_rst  = 1'b1;
  int          drop_left = 0;
  int          err_cnt   = 0;
  int          check_cnt = 0;
  int          misp_cnt  = 0;
  int          exc_cnt   = 0;
  int          drop_cnt  = 0;
  expect_t     exp_q[$];

  tb_clk_gen #(.CLK_PERIOD(CLK_PERIOD), .RST_CYCLES(RST_CYCLES)) i_clk_gen (
    .clk_o (clk),
    .rst_o (rst_i)
  );

  bru_top i_dut (
    .clk_i              (clk),
    .rst_i              (rst_i),
    .issue_valid_i      (issue_valid_i),
    .issue_i            (issue_i),
    .predict_i          (predict_i),
    .resolve_o          (resolve_o),
    .resolved_branch_o  (resolved_branch_o),
    .branch_result_o    (branch_result_o),
    .branch_exception_o (branch_exception_o)
  );

  // two LCG steps, only the upper halves are used since the low bits repeat quickly
  function automatic logic [31:0] next_rand();
    logic [15:0] hi;
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    hi = rng_state[31:16];
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return {hi, rng_state[31:16]};
  endfunction

  // expected resolution of one instruction, worked out from the ISA rules
  function automatic expect_t model_resolve(input bru_pkg::bru_issue_t iss,
                                            input bru_pkg::branch_predict_t pr);
    expect_t         e;
    logic            eq;
    logic            lt_u;
    logic            lt_s;
    logic            cond;
    logic            taken;
    bru_pkg::vaddr_t target;
    bru_pkg::vaddr_t link;
    e    = '0;
    eq   = (iss.operand_a == iss.operand_b);
    lt_u = (iss.operand_a < iss.operand_b);
    // flipping both sign bits maps the signed order onto the unsigned one
    lt_s = ((iss.operand_a ^ SIGN_BIT) < (iss.operand_b ^ SIGN_BIT));
    cond = 1'b1;
    case (iss.op)
      bru_pkg::BEQ:  taken = eq;
      bru_pkg::BNE:  taken = !eq;
      bru_pkg::BLT:  taken = lt_s;
      bru_pkg::BGE:  taken = !lt_s;
      bru_pkg::BLTU: taken = lt_u;
      bru_pkg::BGEU: taken = !lt_u;
      default: begin
        taken = 1'b1;
        cond  = 1'b0;
      end
    endcase
    target = ((iss.op == bru_pkg::JALR) ? iss.operand_a : iss.pc) + iss.imm;
    if (iss.op == bru_pkg::JALR) begin
      target[0] = 1'b0;
    end
    link = iss.pc + (iss.is_compressed ? bru_pkg::vaddr_t'(2) : bru_pkg::vaddr_t'(4));
    e.res.valid          = 1'b1;
    e.res.pc             = iss.pc;
    e.res.target_address = taken ? target : link;
    e.res.is_taken       = taken;
    e.res.cf_type        = pr.cf;
    if (cond) begin
      e.res.cf_type       = bru_pkg::Branch;
      e.res.is_mispredict = (taken != (pr.cf == bru_pkg::Branch));
    end else if (iss.op == bru_pkg::JALR &&
                 (pr.cf == bru_pkg::NoCF || pr.predict_address != target)) begin
      e.res.is_mispredict = 1'b1;
      // a wrong return prediction keeps its Return kind
      if (pr.cf != bru_pkg::Return) begin
        e.res.cf_type = bru_pkg::JumpR;
      end
    end
    e.result    = link;
    // odd targets always trap, bit 1 only matters without 16-bit instructions
    e.exc.valid = taken && (target[0] || ((`BRU_RVC == 0) && target[1]));
    e.exc.cause = '0;
    e.exc.tval  = (`BRU_TVAL_EN != 0) ? iss.pc : '0;
    return e;
  endfunction

  // one random instruction with its prediction
  task automatic make_stimulus(output logic valid, output bru_pkg::bru_issue_t iss,
                               output bru_pkg::branch_predict_t pr);
    logic [31:0] ctl;
    logic [31:0] r;
    logic [2:0]  cf_sel;
    expect_t     e;
    ctl   = next_rand();
    valid = (ctl[7:0] < 8'd200);
    iss.op        = bru_pkg::bru_op_e'(ctl[10:8]);
    iss.operand_a = next_rand();
    r = next_rand();
    // equal operands are common, also close values and opposite signs
    case (ctl[13:11])
      3'd0, 3'd1, 3'd2: iss.operand_b = iss.operand_a;
      3'd3: iss.operand_b = iss.operand_a + {{28{r[3]}}, r[3:0]};
      3'd4: iss.operand_b = iss.operand_a ^ SIGN_BIT;
      default: iss.operand_b = r;
    endcase
    r = next_rand();
    iss.imm = {{20{r[11]}}, r[11:0]};
    // mostly word aligned offsets, sometimes odd or half-word ones
    case (ctl[16:14])
      3'd0: iss.imm[1:0] = 2'b01;
      3'd1: iss.imm[1:0] = 2'b10;
      default: iss.imm[1:0] = 2'b00;
    endcase
    iss.is_compressed = ctl[17];
    r = next_rand();
    iss.pc = {r[31:2], iss.is_compressed & r[1], 1'b0};
    cf_sel = ctl[20:18];
    if (cf_sel > 3'd4) begin
      cf_sel = cf_sel - 3'd3;
    end
    pr.cf = bru_pkg::cf_e'(cf_sel);
    pr.predict_address = '0;
    // half of the address predictions are right, the target does not depend on them
    e = model_resolve(iss, pr);
    pr.predict_address = ctl[21] ? e.res.target_address : next_rand();
  endtask

  // reference model step at a rising edge, reads what the DUT has just sampled
  task automatic update_model();
    expect_t e;
    logic    dropping;
    last_rst = rst_i;
    if (rst_i) begin
      exp_q.delete();
      drop_left = 0;
    end else begin
      // the two edges after a mispredict is accepted carry wrong-path issues
      dropping = (drop_left != 0);
      if (dropping) begin
        drop_left--;
      end
      if (issue_valid_i && dropping) begin
        drop_cnt++;
      end else if (issue_valid_i) begin
        e = model_resolve(issue_i, predict_i);
        e.due = edge_cnt + 1;
        exp_q.push_back(e);
        if (e.res.is_mispredict) begin
          drop_left = 2;
          misp_cnt++;
        end
        if (e.exc.valid) begin
          exc_cnt++;
        end
      end
    end
  endtask

  task automatic compare_value(input string name, input logic [63:0] exp_v,
                               input logic [63:0] got_v);
    check_cnt++;
    assert (got_v === exp_v) else begin
      err_cnt++;
      $display("ERR %0t %s expected %0h actual %0h", $time, name, exp_v, got_v);
    end
  endtask

  // outputs are looked at on the falling edge, half a cycle after they change
  task automatic check_outputs();
    expect_t e;
    if (!last_rst && exp_q.size() != 0 && exp_q[0].due == edge_cnt) begin
      e = exp_q.pop_front();
      compare_value("resolve_o", 1, resolve_o);
      compare_value("resolved_branch_o.valid", 1, resolved_branch_o.valid);
      compare_value("resolved_branch_o.pc", e.res.pc, resolved_branch_o.pc);
      compare_value("resolved_branch_o.target_address", e.res.target_address,
                    resolved_branch_o.target_address);
      compare_value("resolved_branch_o.is_taken", e.res.is_taken, resolved_branch_o.is_taken);
      compare_value("resolved_branch_o.is_mispredict", e.res.is_mispredict,
                    resolved_branch_o.is_mispredict);
      compare_value("resolved_branch_o.cf_type", e.res.cf_type, resolved_branch_o.cf_type);
      compare_value("branch_result_o", e.result, branch_result_o);
      compare_value("branch_exception_o.valid", e.exc.valid, branch_exception_o.valid);
      if (e.exc.valid) begin
        compare_value("branch_exception_o.cause", e.exc.cause, branch_exception_o.cause);
        compare_value("branch_exception_o.tval", e.exc.tval, branch_exception_o.tval);
      end
    end else begin
      // nothing due, so also nothing may be resolved, this covers reset too
      compare_value("resolve_o", 0, resolve_o);
      compare_value("resolved_branch_o.valid", 0, resolved_branch_o.valid);
      compare_value("branch_exception_o.valid", 0, branch_exception_o.valid);
    end
  endtask

  initial begin : main
    logic                     nxt_valid;
    bru_pkg::bru_issue_t      nxt_issue;
    bru_pkg::branch_predict_t nxt_pred;
    int                       stim_cnt;
    stim_cnt      = 0;
    issue_valid_i = 1'b0;
    issue_i       = '0;
    predict_i     = '0;
    for (int cyc = 0; cyc < RUN_CYCLES; cyc++) begin
      @(posedge clk);
      edge_cnt = edge_cnt + 1;
      update_model();
      if (!rst_i && stim_cnt < NUM_CYCLES) begin
        make_stimulus(nxt_valid, nxt_issue, nxt_pred);
        stim_cnt++;
      end else begin
        nxt_valid = 1'b0;
        nxt_issue = '0;
        nxt_pred  = '0;
      end
      issue_valid_i <= nxt_valid;
      issue_i       <= nxt_issue;
      predict_i     <= nxt_pred;
      @(negedge clk);
      check_outputs();
    end
    assert (exp_q.size() == 0) else begin
      err_cnt++;
      $display("%0d expected resolutions never appeared at the outputs", exp_q.size());
    end
    assert (misp_cnt > 0 && exc_cnt > 0 && drop_cnt > 0) else begin
      err_cnt++;
      $display("the stimulus never produced a mispredict, an exception or a dropped issue");
    end
    $display("checks %0d, errors %0d, mispredicts %0d, exceptions %0d, dropped issues %0d",
             check_cnt, err_cnt, misp_cnt, exc_cnt, drop_cnt);
    if (err_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // stops a run that hangs well past the planned number of cycles
  initial begin : watchdog
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("the run timed out after %0d cycles without finishing", TIMEOUT_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: tb/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen #(
  parameter int CLK_PERIOD = 100,
  parameter int RST_CYCLES = 4
) (
  output logic clk_o,
  output logic rst_o
);

  // free running clock that starts low
  initial begin : clock
    clk_o = 1'b0;
    forever begin
      #(CLK_PERIOD / 2);
      clk_o = ~clk_o;
    end
  end

  // reset is seen high by the first RST_CYCLES rising edges
  initial begin : reset
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule
